// ==== hw/spi_resp_defines.svh ====
`ifndef SPI_RESP_DEFINES_SVH
`define SPI_RESP_DEFINES_SVH

// width of one whole response word handed over by a source
`define RESP_BITS 32

// width of one chunk on the SPI transmit side
`define CHUNK_BITS 8

// a response word is cut into this many chunks
`define CHUNKS_PER_RESP 4

// response sources at the top level and the width of their id
`define NUM_SOURCES 3
`define SRC_ID_BITS 2

`endif

// ==== hw/spi_resp_pkg.sv ====
`default_nettype none

`include "spi_resp_defines.svh"

package spi_resp_pkg;

  // one whole response word as it arrives from a source
  typedef logic [`RESP_BITS-1:0] resp_data_t;

  // one chunk of a response word
  typedef logic [`CHUNK_BITS-1:0] chunk_t;

  // index of a response source
  typedef logic [`SRC_ID_BITS-1:0] src_id_t;

  // outgoing frame with the source id above the chunk
  typedef logic [`SRC_ID_BITS+`CHUNK_BITS-1:0] frame_t;

  // counts the chunks of a word down to zero
  typedef logic [1:0] chunk_idx_t;

  // the disassembler either waits for a word or sends its chunks
  typedef enum logic {IDLE, SEND} disasm_state_e;

endpackage

`default_nettype wire

// ==== hw/chunk_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// a val/rdy stream of chunks, with last marking the final chunk of a packet
interface chunk_stream_if import spi_resp_pkg::*; ();

  // the producer raises val and holds msg and last until rdy is seen
  logic   val;
  chunk_t msg;
  logic   last;

  // the consumer drives rdy, and it may look at val to do so
  logic   rdy;

  // the disassembler side of the stream
  modport source (
    output val,
    output msg,
    output last,
    input  rdy
  );

  // the arbiter side of the stream
  modport sink (
    input  val,
    input  msg,
    input  last,
    output rdy
  );

endinterface

`default_nettype wire

// ==== hw/packet_disassembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_resp_defines.svh"

// cuts one response word into chunks and sends them most significant first
module packet_disassembler import spi_resp_pkg::*; (
  input  logic            clk,
  input  logic            reset,

  // response word from the source
  input  logic            resp_val,
  output logic            resp_rdy,
  input  resp_data_t      resp_msg,

  // chunk stream towards the arbiter
  chunk_stream_if.source  out
);

  disasm_state_e state_q;
  disasm_state_e state_d;

  // index of the chunk presented on the stream
  chunk_idx_t idx_q;
  chunk_idx_t idx_d;

  // the word being sent, held for the whole packet
  resp_data_t word_q;

  logic chunk_fire;
  logic word_fire;

  // a new word is only taken while nothing is being sent
  assign resp_rdy = (state_q == IDLE);

  assign word_fire  = resp_val && resp_rdy;
  assign chunk_fire = out.val && out.rdy;

  // the stream is valid for the whole time the word is being sent
  assign out.val  = (state_q == SEND);
  assign out.msg  = word_q[idx_q * `CHUNK_BITS +: `CHUNK_BITS];
  assign out.last = (state_q == SEND) && (idx_q == '0);

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    case (state_q)
      IDLE: begin
        // start from the most significant chunk of the new word
        if (word_fire) begin
          state_d = SEND;
          idx_d   = chunk_idx_t'(`CHUNKS_PER_RESP - 1);
        end
      end
      SEND: begin
        if (chunk_fire) begin
          // the final chunk hands the stage back to the source side
          if (idx_q == '0) begin
            state_d = IDLE;
          end else begin
            idx_d = idx_q - 1'b1;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      idx_q   <= chunk_idx_t'(`CHUNKS_PER_RESP - 1);
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  // the payload register only loads when a word is accepted
  always_ff @(posedge clk) begin
    if (word_fire) begin
      word_q <= resp_msg;
    end
  end

  // a stalled chunk must not change until the arbiter takes it
  chunk_held_a: assert property (
    @(posedge clk) disable iff (reset)
    out.val && !out.rdy |=> out.val && $stable(out.msg) && $stable(out.last)
  ) else $error("chunk changed while stalled");

  // an accepted word shows its top chunk one cycle later
  // and the source side stays blocked while it is being sent
  first_chunk_a: assert property (
    @(posedge clk) disable iff (reset)
    word_fire |=> out.val && !resp_rdy
      && (out.msg == $past(resp_msg[`RESP_BITS-1 -: `CHUNK_BITS]))
  ) else $error("accepted word did not start with its top chunk");

endmodule

`default_nettype wire

// ==== hw/response_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_resp_defines.svh"

// picks one chunk stream at a time and tags each chunk with the source id
// a source keeps the grant from its first chunk until its last one is taken
module response_arbiter import spi_resp_pkg::*; #(
  parameter int num_sources = 2
) (
  input  logic          clk,
  input  logic          reset,

  // chunk streams from the disassemblers
  chunk_stream_if.sink  in [num_sources],

  // tagged frames towards the SPI transmit side
  output logic          frame_val,
  input  logic          frame_rdy,
  output frame_t        frame_msg,
  output logic          frame_last
);

  // the id of every source must fit in the frame header
  if (num_sources < 2 || num_sources > (1 << `SRC_ID_BITS)) begin : g_bad_count
    $error("response_arbiter needs 2 to %0d sources", 1 << `SRC_ID_BITS);
  end

  // flat copies of the stream signals so they can be indexed in loops
  logic   in_val  [num_sources];
  chunk_t in_msg  [num_sources];
  logic   in_last [num_sources];
  logic   [num_sources-1:0] in_rdy;

  for (genvar g = 0; g < num_sources; g++) begin : g_port
    assign in_val[g]  = in[g].val;
    assign in_msg[g]  = in[g].msg;
    assign in_last[g] = in[g].last;
    assign in[g].rdy  = in_rdy[g];
  end

  // set while a packet is partly sent and paired with the source that owns it
  logic    locked_q;
  src_id_t owner_q;

  src_id_t enc_id;
  src_id_t grant_id;
  chunk_t  grant_msg;
  logic    frame_fire;

  // fixed priority encoder where the lowest valid index wins
  always_comb begin
    enc_id = '0;
    for (int i = num_sources - 1; i >= 0; i--) begin
      if (in_val[i]) begin
        enc_id = src_id_t'(i);
      end
    end
  end

  // a packet in flight keeps its owner, otherwise the encoder decides
  assign grant_id = locked_q ? owner_q : enc_id;

  // route the granted stream to the output and only give it the ready
  always_comb begin
    frame_val  = 1'b0;
    grant_msg  = '0;
    frame_last = 1'b0;
    for (int j = 0; j < num_sources; j++) begin
      if (grant_id == src_id_t'(j)) begin
        frame_val  = in_val[j];
        grant_msg  = in_msg[j];
        frame_last = in_last[j];
        in_rdy[j]  = frame_rdy;
      end else begin
        in_rdy[j]  = 1'b0;
      end
    end
  end

  // the source id goes in front of the chunk
  assign frame_msg = {grant_id, grant_msg};

  assign frame_fire = frame_val && frame_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      locked_q <= 1'b0;
      owner_q  <= '0;
    end else if (frame_fire) begin
      // a taken chunk that is not the last one pins the grant
      locked_q <= !frame_last;
      owner_q  <= grant_id;
    end
  end

  // the rest of a packet follows from the same source without a gap in val
  owner_kept_a: assert property (
    @(posedge clk) disable iff (reset)
    frame_fire && !frame_last |=> frame_val && (grant_id == $past(grant_id))
  ) else $error("packet was interrupted by another source");

  // under back-pressure the offered frame stays exactly as it is
  frame_held_a: assert property (
    @(posedge clk) disable iff (reset)
    frame_val && !frame_rdy |=> frame_val && $stable(frame_msg) && $stable(frame_last)
  ) else $error("frame changed while stalled");

endmodule

`default_nettype wire

// ==== hw/spi_resp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_resp_defines.svh"

// response return path with one disassembler per source and a shared arbiter
module spi_resp_top import spi_resp_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  // one response port per source
  input  logic       resp_val [`NUM_SOURCES],
  output logic       resp_rdy [`NUM_SOURCES],
  input  resp_data_t resp_msg [`NUM_SOURCES],

  // tagged frames towards the SPI transmit side
  output logic       frame_val,
  input  logic       frame_rdy,
  output frame_t     frame_msg,
  output logic       frame_last
);

  // one chunk stream between each disassembler and the arbiter
  chunk_stream_if chunk_if [`NUM_SOURCES] ();

  // each source gets its own disassembler
  // which holds the word while its chunks go out
  for (genvar g = 0; g < `NUM_SOURCES; g++) begin : g_src
    packet_disassembler disasm_i (
      .clk      (clk),
      .reset    (reset),
      .resp_val (resp_val[g]),
      .resp_rdy (resp_rdy[g]),
      .resp_msg (resp_msg[g]),
      .out      (chunk_if[g])
    );
  end

  // the arbiter adds no latency
  // so the first frame leaves one cycle after a word is accepted
  response_arbiter #(
    .num_sources (`NUM_SOURCES)
  ) arbiter_i (
    .clk        (clk),
    .reset      (reset),
    .in         (chunk_if),
    .frame_val  (frame_val),
    .frame_rdy  (frame_rdy),
    .frame_msg  (frame_msg),
    .frame_last (frame_last)
  );

endmodule

`default_nettype wire

// ==== tests/spi_resp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_resp_defines.svh"

module spi_resp_tb import spi_resp_pkg::*; ();

  localparam int WAIT_LIMIT    = 400;
  localparam int TRAFFIC_LIMIT = 4000;

  logic       clk;
  logic       reset;
  logic       resp_val [`NUM_SOURCES];
  logic       resp_rdy [`NUM_SOURCES];
  resp_data_t resp_msg [`NUM_SOURCES];
  logic       frame_val;
  logic       frame_rdy;
  frame_t     frame_msg;
  logic       frame_last;

  spi_resp_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .resp_msg   (resp_msg),
    .frame_val  (frame_val),
    .frame_rdy  (frame_rdy),
    .frame_msg  (frame_msg),
    .frame_last (frame_last)
  );

  always #4 clk = ~clk;

  // the frame split back into its id and its chunk
  src_id_t frame_id;
  chunk_t  frame_chunk;
  logic    frame_fire;
  logic [`NUM_SOURCES-1:0] val_vec;
  logic [`NUM_SOURCES-1:0] rdy_vec;
  logic [`NUM_SOURCES-1:0] accept_vec;

  assign {frame_id, frame_chunk} = frame_msg;
  assign frame_fire = frame_val && frame_rdy;

  for (genvar g = 0; g < `NUM_SOURCES; g++) begin : g_vec
    assign val_vec[g] = resp_val[g];
    assign rdy_vec[g] = resp_rdy[g];
  end
  assign accept_vec = val_vec & rdy_vec;

  // scoreboard with one queue of expected words per source
  resp_data_t exp_q [`NUM_SOURCES][$];
  logic [`RESP_BITS-`CHUNK_BITS-1:0] partial [`NUM_SOURCES];
  // a source is busy from the accepted word until its last chunk leaves
  logic [`NUM_SOURCES-1:0] busy;
  chunk_idx_t pkt_cnt;
  logic       chk_valid;
  logic       chk_empty;
  src_id_t    chk_id;
  resp_data_t chk_got;
  resp_data_t chk_exp;
  int         queued;
  logic       end_check;

  int   value_errors = 0;
  int   protocol_errors = 0;
  int   timeout_errors = 0;
  logic timed_out;
  logic [31:0] lcg_state;
  int   words_sent;

  always @(posedge clk) begin : monitor
    logic [`NUM_SOURCES-1:0] busy_nx;
    resp_data_t front;
    int total;
    chk_valid <= 1'b0;
    if (reset) begin
      busy    <= '0;
      pkt_cnt <= '0;
      queued  <= 0;
    end else begin
      busy_nx = busy | accept_vec;
      for (int s = 0; s < `NUM_SOURCES; s++) begin
        if (accept_vec[s]) begin
          exp_q[s].push_back(resp_msg[s]);
        end
      end
      if (frame_fire && int'(frame_id) < `NUM_SOURCES) begin
        if (frame_last) begin
          // the word is rebuilt from the three stored chunks and this one
          front = '0;
          chk_empty <= (exp_q[frame_id].size() == 0);
          if (exp_q[frame_id].size() != 0) begin
            front = exp_q[frame_id].pop_front();
          end
          chk_valid <= 1'b1;
          chk_id    <= frame_id;
          chk_got   <= {partial[frame_id], frame_chunk};
          chk_exp   <= front;
          busy_nx[frame_id] = 1'b0;
          pkt_cnt   <= '0;
        end else begin
          partial[frame_id] <= {partial[frame_id][`RESP_BITS-2*`CHUNK_BITS-1:0], frame_chunk};
          pkt_cnt <= pkt_cnt + chunk_idx_t'(1);
        end
      end
      total = 0;
      for (int s = 0; s < `NUM_SOURCES; s++) begin
        total += exp_q[s].size();
      end
      busy   <= busy_nx;
      queued <= total;
    end
  end

  // fixed priority picks the first busy source counting up from zero
  function automatic src_id_t lowest_set(input logic [`NUM_SOURCES-1:0] v);
    src_id_t id;
    logic    found;
    id = '0;
    found = 1'b0;
    for (int i = 0; i < `NUM_SOURCES; i++) begin
      if (v[i] && !found) begin
        id = src_id_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic any_val();
    logic v;
    v = 1'b0;
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      v = v | resp_val[s];
    end
    return v;
  endfunction

  // frame_val is high exactly while some source has a word inside
  frame_val_a: assert property (@(posedge clk) disable iff (reset)
    frame_val == (busy != '0)
  ) else begin
    value_errors++;
    $display("Mismatch frame_val: got %h expected %h", $sampled(frame_val),
             $sampled(busy) != '0);
  end

  // a source can hand over a word only while its disassembler is idle
  resp_rdy_a: assert property (@(posedge clk) disable iff (reset)
    rdy_vec == ~busy
  ) else begin
    value_errors++;
    $display("Mismatch resp_rdy: got %h expected %h", $sampled(rdy_vec), ~$sampled(busy));
  end

  first_frame_a: assert property (@(posedge clk) disable iff (reset)
    !frame_val && (accept_vec != '0) |=> frame_val
  ) else begin
    protocol_errors++;
    $display("no frame one cycle after a word was accepted on an idle path");
  end

  last_pos_a: assert property (@(posedge clk) disable iff (reset)
    frame_fire |-> frame_last == (pkt_cnt == chunk_idx_t'(`CHUNKS_PER_RESP - 1))
  ) else begin
    value_errors++;
    $display("Mismatch frame_last: got %h expected %h", $sampled(frame_last),
             $sampled(pkt_cnt) == chunk_idx_t'(`CHUNKS_PER_RESP - 1));
  end

  // once a packet has started, its owner keeps the output until the last chunk
  same_owner_a: assert property (@(posedge clk) disable iff (reset)
    frame_fire && !frame_last |=> frame_val && frame_id == $past(frame_id)
  ) else begin
    protocol_errors++;
    $display("frames of two packets were interleaved");
  end

  priority_a: assert property (@(posedge clk) disable iff (reset)
    frame_fire && pkt_cnt == '0 |-> frame_id == lowest_set(busy)
  ) else begin
    value_errors++;
    $display("Mismatch frame_id: got %h expected %h", $sampled(frame_id),
             lowest_set($sampled(busy)));
  end

  hold_a: assert property (@(posedge clk) disable iff (reset)
    frame_val && !frame_rdy |=> frame_val && $stable(frame_msg) && $stable(frame_last)
  ) else begin
    protocol_errors++;
    $display("the offered frame changed while frame_rdy was low");
  end

  sb_empty_a: assert property (@(posedge clk) disable iff (reset)
    chk_valid |-> !chk_empty
  ) else begin
    protocol_errors++;
    $display("a packet from source %0d came out with no word expected", $sampled(chk_id));
  end

  sb_word_a: assert property (@(posedge clk) disable iff (reset)
    chk_valid && !chk_empty |-> chk_got == chk_exp
  ) else begin
    value_errors++;
    $display("Mismatch resp_msg of source %0d: got %h expected %h", $sampled(chk_id),
             $sampled(chk_got), $sampled(chk_exp));
  end

  drained_a: assert property (@(posedge clk) disable iff (reset)
    end_check |-> queued == 0
  ) else begin
    protocol_errors++;
    $display("%0d accepted words never came out", $sampled(queued));
  end

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    timeout_errors++;
    $display("timed out while %s", what);
  endtask

  // step to the next falling edge and drop val where the word was just taken
  task automatic next_cycle();
    logic [`NUM_SOURCES-1:0] taking;
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      taking[s] = resp_val[s] && resp_rdy[s];
    end
    @(negedge clk);
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      if (taking[s]) begin
        resp_val[s] = 1'b0;
      end
    end
  endtask

  task automatic offer_word(input int src);
    resp_msg[src] = next_random();
    resp_val[src] = 1'b1;
    words_sent++;
  endtask

  task automatic wait_taken();
    int waited;
    waited = 0;
    while (any_val() && !timed_out) begin
      next_cycle();
      waited++;
      if (waited >= WAIT_LIMIT) begin
        report_timeout("waiting for a response word to be accepted");
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    frame_rdy = 1'b1;
    while ((any_val() || busy != '0) && !timed_out) begin
      next_cycle();
      waited++;
      if (waited >= WAIT_LIMIT) begin
        report_timeout("waiting for the packets to leave");
      end
    end
    // two more edges let the last compare reach its check
    next_cycle();
    next_cycle();
  endtask

  // at a packet boundary a lower source that arrives takes the grant,
  // so a stalled frame is released before that can happen
  task automatic keep_frame_steady();
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      if (frame_val && pkt_cnt == '0 && resp_val[s] && resp_rdy[s] && s < int'(frame_id)) begin
        frame_rdy = 1'b1;
      end
    end
  endtask

  task automatic random_traffic(input int words);
    int cycles;
    int target;
    logic [31:0] r;
    cycles = 0;
    target = words_sent + words;
    while (words_sent < target && !timed_out) begin
      next_cycle();
      r = next_random();
      frame_rdy = (r[31:29] > 3'd1);
      for (int s = 0; s < `NUM_SOURCES; s++) begin
        r = next_random();
        if (!resp_val[s] && r[31:30] != 2'b00 && words_sent < target) begin
          offer_word(s);
        end
      end
      keep_frame_steady();
      cycles++;
      if (cycles >= TRAFFIC_LIMIT) begin
        report_timeout("sending random traffic");
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    frame_rdy = 1'b0;
    end_check = 1'b0;
    timed_out = 1'b0;
    words_sent = 0;
    lcg_state = 32'd82519;
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      resp_val[s] = 1'b0;
      resp_msg[s] = '0;
    end
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // idle after reset, nothing offered
    frame_rdy = 1'b1;
    repeat (3) next_cycle();

    // one word from source 1 with frame_rdy held high
    offer_word(1);
    wait_taken();
    drain();

    // all sources at once come out in id order
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      offer_word(s);
    end
    wait_taken();
    drain();

    // source 0 arrives in the middle of a packet from source 2
    offer_word(2);
    wait_taken();
    next_cycle();
    offer_word(0);
    wait_taken();
    drain();

    // random words and random back-pressure
    random_traffic(72);
    drain();

    end_check = 1'b1;
    next_cycle();
    end_check = 1'b0;
    next_cycle();

    $display("errors: %0d value, %0d protocol, %0d timeout", value_errors, protocol_errors,
             timeout_errors);
    if (value_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/spi_resp_pkg.sv
hw/chunk_stream_if.sv
hw/packet_disassembler.sv
hw/response_arbiter.sv
hw/spi_resp_top.sv
tests/spi_resp_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 -f src.f --top-module spi_resp_tb -o spi_resp_sim

# the simulation passes only if the pass line shows up in its output
run: compile
	@out=$$(./obj_dir/spi_resp_sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
